// ==== src/board_bus.sv ====
`timescale 1ns/1ps

module board_bus
    import soc_pkg::*;
(
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  bus_req_t bus_req,
    output xdata_t   read_data,
    input  logic     irq_ack,
    output irq_vec_t irq_vector,
    output logic     uart_write,
    output word_t    uart_data,
    input  logic     ps2_clk,
    input  logic     ps2_dat
);

    // Decoder to RAM
    logic       ram_we;
    ram_index_t ram_index;
    word_t      ram_wdata;
    word_t      ram_rdata;

    // Keyboard path
    logic       scan_valid;
    scan_t      scan;
    ascii_t     key_ascii;

    bus_decoder u_decoder (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .bus_req    (bus_req),
        .key_ascii  (key_ascii),
        .ram_rdata  (ram_rdata),
        .ram_we     (ram_we),
        .ram_index  (ram_index),
        .ram_wdata  (ram_wdata),
        .read_data  (read_data),
        .uart_write (uart_write),
        .uart_data  (uart_data)
    );

    onchip_ram u_ram (
        .CLOCK_50 (CLOCK_50),
        .we       (ram_we),
        .index    (ram_index),
        .wdata    (ram_wdata),
        .rdata    (ram_rdata)
    );

    // PS/2 receiver feeds the keyboard register block
    ps2_receiver u_ps2 (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .scan_valid (scan_valid),
        .scan       (scan)
    );

    keyboard_regs u_keyboard (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .scan_valid (scan_valid),
        .scan       (scan),
        .irq_ack    (irq_ack),
        .key_ascii  (key_ascii),
        .irq_vector (irq_vector)
    );

endmodule

// ==== src/bus_decoder.sv ====
`timescale 1ns/1ps
`include "soc_settings.svh"

module bus_decoder
    import soc_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  bus_req_t   bus_req,
    input  ascii_t     key_ascii,
    input  word_t      ram_rdata,
    output logic       ram_we,
    output ram_index_t ram_index,
    output word_t      ram_wdata,
    output xdata_t     read_data,
    output logic       uart_write,
    output word_t      uart_data
);

    bus_sel_t sel;
    addr_t    ram_offset;
    logic     uart_hit;
    logic     uart_prev;

    // Read strobe and targets, two stages deep
    logic     rd_q1;
    logic     rd_q2;
    bus_sel_t sel_q1;
    bus_sel_t sel_q2;

    // Address compare against the memory map
    always_comb begin
        sel      = '0;
        sel.ram  = (bus_req.addr >= `RAM_BASE) && (bus_req.addr < `RAM_LIMIT);
        sel.key  = (bus_req.addr == `KEY_BASE);
        sel.uart = (bus_req.addr == `UART_BASE);
    end

    // Word index from the byte offset into the RAM
    assign ram_offset = bus_req.addr - `RAM_BASE;
    assign ram_index  = ram_index_t'(ram_offset >> 2);
    assign ram_we     = bus_req.we && sel.ram;
    assign ram_wdata  = bus_req.wdata[31:0];

    // UART strobe fires on the first cycle of a write only
    assign uart_hit   = bus_req.we && sel.uart;
    assign uart_write = uart_hit && !uart_prev;
    assign uart_data  = bus_req.wdata[31:0];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            uart_prev <= 1'b0;
        end else begin
            uart_prev <= uart_hit;
        end
    end

    // Targets travel with the read strobe until the RAM word is out
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_q1  <= 1'b0;
            rd_q2  <= 1'b0;
            sel_q1 <= '0;
            sel_q2 <= '0;
        end else begin
            rd_q1  <= bus_req.re;
            rd_q2  <= rd_q1;
            sel_q1 <= sel;
            sel_q2 <= sel_q1;
        end
    end

    // Registered read mux
    // Holds its value for unmapped reads and idle cycles
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_data <= '0;
        end else if (rd_q2) begin
            if (sel_q2.ram) begin
                read_data <= {32'd0, ram_rdata};
            end else if (sel_q2.key) begin
                read_data <= {56'd0, key_ascii};
            end
        end
    end

endmodule

// ==== src/keyboard_regs.sv ====
`timescale 1ns/1ps
`include "soc_settings.svh"

module keyboard_regs
    import soc_pkg::*;
(
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  logic     scan_valid,
    input  scan_t    scan,
    input  logic     irq_ack,
    output ascii_t   key_ascii,
    output irq_vec_t irq_vector
);

    // Set-2 make code to lower-case ASCII, zero when unmapped
    function automatic ascii_t scan_to_ascii(input scan_t code);
        case (code)
            8'h1C: return "a";
            8'h32: return "b";
            8'h21: return "c";
            8'h23: return "d";
            8'h24: return "e";
            8'h2B: return "f";
            8'h34: return "g";
            8'h33: return "h";
            8'h43: return "i";
            8'h3B: return "j";
            8'h42: return "k";
            8'h4B: return "l";
            8'h3A: return "m";
            8'h31: return "n";
            8'h44: return "o";
            8'h4D: return "p";
            8'h15: return "q";
            8'h2D: return "r";
            8'h1B: return "s";
            8'h2C: return "t";
            8'h3C: return "u";
            8'h2A: return "v";
            8'h1D: return "w";
            8'h22: return "x";
            8'h35: return "y";
            8'h1A: return "z";
            8'h45: return "0";
            8'h16: return "1";
            8'h1E: return "2";
            8'h26: return "3";
            8'h25: return "4";
            8'h2E: return "5";
            8'h36: return "6";
            8'h3D: return "7";
            8'h3E: return "8";
            8'h46: return "9";
            8'h29: return " ";
            // Enter gives carriage return
            8'h5A: return 8'h0D;
            default: return 8'h00;
        endcase
    endfunction

    ascii_t code_ascii;
    logic   break_seen;
    logic   key_hit;

    assign code_ascii = scan_to_ascii(scan);
    // A make code with a mapping, not following a break prefix
    assign key_hit = scan_valid && !break_seen && (scan != `PS2_BREAK) && (code_ascii != '0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            break_seen <= 1'b0;
            key_ascii  <= '0;
            irq_vector <= '0;
        end else begin
            // Break prefix arms the flag, the next code clears it
            if (scan_valid) begin
                break_seen <= (scan == `PS2_BREAK);
            end
            if (key_hit) begin
                key_ascii <= code_ascii;
            end
            // Acknowledge wins over a new key
            if (irq_vector != '0 && irq_ack) begin
                irq_vector <= '0;
            end else if (key_hit) begin
                irq_vector <= irq_vec_t'(1);
            end
        end
    end

endmodule

// ==== src/onchip_ram.sv ====
`timescale 1ns/1ps
`include "soc_settings.svh"

module onchip_ram
    import soc_pkg::*;
#(
    parameter int DEPTH = `RAM_WORDS
) (
    input  logic       CLOCK_50,
    input  logic       we,
    input  ram_index_t index,
    input  word_t      wdata,
    output word_t      rdata
);

    word_t      mem [0:DEPTH-1];
    ram_index_t index_q;

    // Write port
    always_ff @(posedge CLOCK_50) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

    // Address captured every cycle, read or not
    always_ff @(posedge CLOCK_50) begin
        index_q <= index;
    end

    // Data out one edge after the address register
    // Same-edge write to that word still shows the old word here
    always_ff @(posedge CLOCK_50) begin
        rdata <= mem[index_q];
    end

endmodule

// ==== src/ps2_receiver.sv ====
`timescale 1ns/1ps
`include "soc_settings.svh"

module ps2_receiver
    import soc_pkg::*;
(
    input  logic  CLOCK_50,
    input  logic  KEY0,
    input  logic  ps2_clk,
    input  logic  ps2_dat,
    output logic  scan_valid,
    output scan_t scan
);

    // Two-flop synchronizers, lines idle high
    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_last;
    logic       clk_fall;

    ps2_state_e state;
    // Bits of the frame taken so far, start bit included
    logic [3:0] bit_cnt;
    // Data bits then parity, LSB first
    logic [8:0] shreg;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_last <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_last <= clk_sync[1];
        end
    end

    // Device drives data on the falling clock edge
    assign clk_fall = clk_last && !clk_sync[1];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= PS2_IDLE;
            bit_cnt    <= '0;
            scan_valid <= 1'b0;
        end else begin
            scan_valid <= 1'b0;
            if (clk_fall) begin
                case (state)
                    PS2_IDLE: begin
                        // Only a low start bit opens a frame
                        if (!dat_sync[1]) begin
                            state   <= PS2_SHIFT;
                            bit_cnt <= 4'd1;
                        end
                    end
                    PS2_SHIFT: begin
                        bit_cnt <= bit_cnt + 4'd1;
                        // Parity is the last bit before the stop bit
                        if (bit_cnt == `PS2_FRAME_BITS - 2) begin
                            state <= PS2_CHECK;
                        end
                    end
                    PS2_CHECK: begin
                        // Stop bit high and odd parity over data plus parity
                        scan_valid <= dat_sync[1] && (^shreg);
                        state      <= PS2_IDLE;
                    end
                    default: state <= PS2_IDLE;
                endcase
            end
        end
    end

    // Frame payload
    always_ff @(posedge CLOCK_50) begin
        if (clk_fall && state == PS2_SHIFT) begin
            shreg <= {dat_sync[1], shreg[8:1]};
        end
        if (clk_fall && state == PS2_CHECK) begin
            scan <= shreg[7:0];
        end
    end

endmodule

// ==== src/soc_pkg.sv ====
`include "soc_settings.svh"

package soc_pkg;

    // Bus address and data
    typedef logic [63:0] addr_t;
    typedef logic [63:0] xdata_t;

    // One on-chip RAM word
    typedef logic [31:0] word_t;

    // Word index into the RAM
    typedef logic [$clog2(`RAM_WORDS)-1:0] ram_index_t;

    // Keyboard codes
    typedef logic [7:0] scan_t;
    typedef logic [7:0] ascii_t;

    // Interrupt vector seen by the master
    typedef logic [3:0] irq_vec_t;

    // One bus cycle as issued by the master
    typedef struct packed {
        addr_t  addr;
        xdata_t wdata;
        logic   we;
        logic   re;
    } bus_req_t;

    // Decoded target of the current address
    typedef struct packed {
        logic ram;
        logic key;
        logic uart;
    } bus_sel_t;

    // PS/2 frame receiver states
    typedef enum logic [1:0] {
        PS2_IDLE,
        PS2_SHIFT,
        PS2_CHECK
    } ps2_state_e;

endpackage

// ==== src/soc_settings.svh ====
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Memory map of the peripheral bus
// All addresses are byte addresses on the 64-bit bus

// First byte of the on-chip RAM
`define RAM_BASE 64'h0000_0000_0000_2000

// RAM size in 32-bit words
`define RAM_WORDS 1024

// One past the last RAM byte
`define RAM_LIMIT (`RAM_BASE + 64'd4 * `RAM_WORDS)

// Keyboard data register, read only
`define KEY_BASE 64'h0000_0000_0000_8000

// Console UART data port, write only
`define UART_BASE 64'h0000_0000_0000_8010

// PS/2 set-2 break prefix
`define PS2_BREAK 8'hF0

// Start, 8 data, odd parity, stop
`define PS2_FRAME_BITS 11

`endif

// ==== testbench/board_bus_chk.sv ====
`timescale 1ns/1ps
`include "soc_settings.svh"

module board_bus_chk
    import soc_pkg::*;
(
    input logic     CLOCK_50,
    input logic     KEY0,
    input bus_req_t bus_req,
    input xdata_t   read_data,
    input logic     irq_ack,
    input irq_vec_t irq_vector,
    input logic     uart_write,
    input word_t    uart_data,
    input logic     ps2_clk,
    input logic     ps2_dat
);

    int unsigned failures = 0;

    // Shadow of every RAM word written over the bus
    word_t       shadow [0:`RAM_WORDS-1];
    logic        ram_hit;
    logic        key_hit;
    logic        uart_hit;
    logic        uart_hit_q;
    ram_index_t  index;
    // Mapped reads in flight and their expected data
    logic [1:0]  rd_v;
    xdata_t      rd_val1;
    xdata_t      rd_val2;
    xdata_t      exp_read;
    // Keyboard model
    ascii_t      exp_key;
    logic        brk;
    logic        ps2_clk_q;
    logic [3:0]  bit_cnt;
    logic [10:0] frame;
    logic [10:0] next_frame;
    // Clocks since the last valid mapped key, saturating
    logic [3:0]  key_age;

    // Set-2 make codes sent by the stimulus
    function automatic ascii_t expected_ascii(input scan_t code);
        case (code)
            8'h1C: return 8'h61;
            8'h32: return 8'h62;
            default: return 8'h00;
        endcase
    endfunction

    assign ram_hit    = (bus_req.addr >= `RAM_BASE) && (bus_req.addr < `RAM_LIMIT);
    assign key_hit    = (bus_req.addr == `KEY_BASE);
    assign uart_hit   = bus_req.we && (bus_req.addr == `UART_BASE);
    assign index      = ram_index_t'((bus_req.addr - `RAM_BASE) >> 2);
    // Frame bits arrive LSB first, start bit ends up in bit 0
    assign next_frame = {ps2_dat, frame[10:1]};

    always_ff @(posedge CLOCK_50) begin
        if (KEY0 && bus_req.we && ram_hit) begin
            shadow[index] <= bus_req.wdata[31:0];
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            uart_hit_q <= 1'b0;
            rd_v       <= 2'b00;
            rd_val1    <= '0;
            rd_val2    <= '0;
            exp_read   <= '0;
            exp_key    <= '0;
            brk        <= 1'b0;
            ps2_clk_q  <= 1'b1;
            bit_cnt    <= '0;
            frame      <= '0;
            key_age    <= 4'hF;
        end else begin
            uart_hit_q <= uart_hit;
            // Read data lands two edges after the read is sampled
            rd_v    <= {rd_v[0], bus_req.re && (ram_hit || key_hit)};
            rd_val1 <= ram_hit ? xdata_t'(shadow[index]) : xdata_t'(exp_key);
            rd_val2 <= rd_val1;
            if (rd_v[1]) begin
                exp_read <= rd_val2;
            end
            ps2_clk_q <= ps2_clk;
            if (key_age != 4'hF) begin
                key_age <= key_age + 4'd1;
            end
            // Falling PS/2 clock takes one frame bit
            if (ps2_clk_q && !ps2_clk) begin
                frame   <= next_frame;
                bit_cnt <= bit_cnt + 4'd1;
                if (bit_cnt == `PS2_FRAME_BITS - 1) begin
                    bit_cnt <= '0;
                    // Start low, stop high, odd parity
                    if (!next_frame[0] && next_frame[10] && ^next_frame[9:1]) begin
                        brk <= (next_frame[8:1] == `PS2_BREAK);
                        if (!brk && expected_ascii(next_frame[8:1]) != 8'h00) begin
                            exp_key <= expected_ascii(next_frame[8:1]);
                            key_age <= '0;
                        end
                    end
                end
            end
        end
    end

    // Outputs clear after reset
    assert property (@(posedge CLOCK_50) $rose(KEY0) |->
                     irq_vector == '0 && read_data == '0 && !uart_write)
        else begin
            failures++;
            $error("ERROR %0t irq_vector/read_data/uart_write got %h/%h/%b expected 0/0/0",
                   $time, $sampled(irq_vector), $sampled(read_data), $sampled(uart_write));
        end

    // Mapped reads two edges later, held otherwise
    assert property (@(posedge CLOCK_50) disable iff (!KEY0) read_data == exp_read)
        else begin
            failures++;
            $error("ERROR %0t read_data got %h expected %h",
                   $time, $sampled(read_data), $sampled(exp_read));
        end

    // One pulse on the first cycle of a UART write
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
                     uart_write == (uart_hit && !uart_hit_q))
        else begin
            failures++;
            $error("ERROR %0t uart_write got %b expected %b",
                   $time, $sampled(uart_write), $sampled(uart_hit && !uart_hit_q));
        end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
                     uart_write |-> uart_data == bus_req.wdata[31:0])
        else begin
            failures++;
            $error("ERROR %0t uart_data got %h expected %h",
                   $time, $sampled(uart_data), $sampled(bus_req.wdata[31:0]));
        end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
                     irq_vector == 4'd0 || irq_vector == 4'd1)
        else begin
            failures++;
            $error("ERROR %0t irq_vector got %h expected 0 or 1", $time, $sampled(irq_vector));
        end

    // Acknowledge clears, no acknowledge holds
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
                     irq_vector != 4'd0 && irq_ack |=> irq_vector == 4'd0)
        else begin
            failures++;
            $error("ERROR %0t irq_vector got %h expected 0", $time, $sampled(irq_vector));
        end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
                     irq_vector != 4'd0 && !irq_ack |=> irq_vector != 4'd0)
        else begin
            failures++;
            $error("irq_vector dropped at %0t without an acknowledge", $time);
        end

    // Interrupt rises only shortly after a valid mapped key
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
                     $rose(irq_vector != 4'd0) |-> key_age < 4'd6)
        else begin
            failures++;
            $error("irq_vector rose at %0t without a valid key frame", $time);
        end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
                     key_age == 4'd0 |-> ##[1:6] irq_vector == 4'd1)
        else begin
            failures++;
            $error("irq_vector not raised at %0t after a valid key frame", $time);
        end

endmodule

// ==== testbench/board_bus_tb.sv ====
`timescale 1ns/1ps
`include "soc_settings.svh"

module board_bus_tb
    import soc_pkg::*;
();

    logic       CLOCK_50;
    logic       KEY0;
    bus_req_t   bus_req;
    xdata_t     read_data;
    logic       irq_ack;
    irq_vec_t   irq_vector;
    logic       uart_write;
    word_t      uart_data;
    logic       ps2_clk;
    logic       ps2_dat;

    integer     seed;
    ram_index_t used [0:39];
    word_t      uart_word;

    tb_clock u_clock (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0)
    );

    board_bus uut (.*);

    bind board_bus board_bus_chk u_chk (.*);

    task automatic abort_run(input string reason);
        $display("ERRORS FOUND");
        $fatal(1, "%s", reason);
    endtask

    function automatic addr_t ram_addr(input ram_index_t idx);
        return `RAM_BASE + (addr_t'(idx) << 2);
    endfunction

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (KEY0 !== 1'b1) begin
            @(negedge CLOCK_50);
            cycles++;
            if (cycles > 20) abort_run("reset was never released");
        end
    endtask

    task automatic write_word(input addr_t addr, input xdata_t data);
        @(posedge CLOCK_50);
        bus_req <= '{addr: addr, wdata: data, we: 1'b1, re: 1'b0};
    endtask

    task automatic read_addr(input addr_t addr);
        @(posedge CLOCK_50);
        bus_req <= '{addr: addr, wdata: '0, we: 1'b0, re: 1'b1};
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge CLOCK_50);
            bus_req <= '0;
        end
    endtask

    // Frame is start, data LSB first, parity and stop
    // Clock high 10 and low 10 cycles per bit
    task automatic send_frame(input scan_t code, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, bad_parity ? ^code : ~^code, code, 1'b0};
        for (int b = 0; b < `PS2_FRAME_BITS; b++) begin
            @(posedge CLOCK_50);
            ps2_dat <= bits[b];
            repeat (9) @(posedge CLOCK_50);
            ps2_clk <= 1'b0;
            repeat (10) @(posedge CLOCK_50);
            ps2_clk <= 1'b1;
        end
    endtask

    task automatic wait_irq(input irq_vec_t value);
        int cycles;
        cycles = 0;
        do begin
            @(negedge CLOCK_50);
            cycles++;
            if (cycles > 100) abort_run("irq_vector never reached the awaited value");
        end while (irq_vector != value);
    endtask

    task automatic pulse_ack();
        @(posedge CLOCK_50);
        irq_ack <= 1'b1;
        @(posedge CLOCK_50);
        irq_ack <= 1'b0;
    endtask

    // Stop at the first assertion failure in the bound checker
    always @(negedge CLOCK_50) begin
        if (uut.u_chk.failures != 0) abort_run("a bus or interrupt assertion failed");
    end

    initial begin
        seed    = 65207;
        bus_req = '0;
        irq_ack = 1'b0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        wait_reset_release();

        // Key register reads zero after reset
        read_addr(`KEY_BASE);

        // Random RAM writes, then reads with some back to back
        for (int i = 0; i < 40; i++) begin
            used[i] = ram_index_t'($unsigned($random(seed)) % `RAM_WORDS);
            write_word(ram_addr(used[i]), {$random(seed), $random(seed)});
        end
        for (int i = 0; i < 40; i++) begin
            read_addr(ram_addr(used[i]));
            if (i % 4 == 3) idle_cycles(2);
        end
        idle_cycles(3);

        // Unmapped writes alias the same low bits and must leave the RAM intact
        for (int i = 0; i < 8; i++) begin
            write_word(`RAM_LIMIT + (addr_t'(used[i]) << 2), {$random(seed), $random(seed)});
            write_word(ram_addr(used[i]) | 64'h0000_0001_0000_0000, {$random(seed), 32'h0});
        end
        for (int i = 0; i < 8; i++) begin
            read_addr(ram_addr(used[i]));
            read_addr(`KEY_BASE + 64'd4);
            read_addr(`UART_BASE);
            read_addr(64'hFFFF_0000_0000_8000);
        end
        idle_cycles(3);

        // UART write held for three cycles
        uart_word = $random(seed);
        repeat (3) write_word(`UART_BASE, {$random(seed), uart_word});
        idle_cycles(3);

        // Key 'a' raises the interrupt
        send_frame(8'h1C, 1'b0);
        wait_irq(4'd1);
        read_addr(`KEY_BASE);
        idle_cycles(3);
        pulse_ack();
        wait_irq(4'd0);

        // Break sequence, unmapped code and bad parity change nothing
        send_frame(`PS2_BREAK, 1'b0);
        send_frame(8'h1C, 1'b0);
        send_frame(8'h76, 1'b0);
        send_frame(8'h32, 1'b1);
        idle_cycles(40);
        read_addr(`KEY_BASE);
        idle_cycles(3);

        // Next valid key raises it again
        send_frame(8'h32, 1'b0);
        wait_irq(4'd1);
        read_addr(`KEY_BASE);
        idle_cycles(5);

        if (uut.u_chk.failures != 0) begin
            abort_run("assertion failures were counted in the checker");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic CLOCK_50,
    output logic KEY0
);

    // 40 ns period
    initial begin
        CLOCK_50 = 1'b0;
        forever #20 CLOCK_50 = ~CLOCK_50;
    end

    // Active-low reset held for five rising edges
    initial begin
        KEY0 = 1'b0;
        repeat (5) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
    end

endmodule

// ==== verilog.f ====
+incdir+src
src/soc_pkg.sv
src/ps2_receiver.sv
src/keyboard_regs.sv
src/bus_decoder.sv
src/onchip_ram.sv
src/board_bus.sv
testbench/tb_clock.sv
testbench/board_bus_chk.sv
testbench/board_bus_tb.sv
